/* logic/mdu_pkg.sv */
`default_nettype none

package mdu_pkg;

    // Iterations per operation, one operand bit per cycle.
    localparam int ITER_COUNT = 32;

    // Iteration counter width.
    localparam int CNT_W = 6;

    // Operand and result word.
    typedef logic [31:0] word_t;

    // Full product of two words.
    typedef logic [63:0] dword_t;

    // M-extension funct3 codes.
    typedef enum logic [2:0] {
        MUL_OP    = 3'b000,
        MULH_OP   = 3'b001,
        MULHSU_OP = 3'b010,
        MULHU_OP  = 3'b011,
        DIV_OP    = 3'b100,
        DIVU_OP   = 3'b101,
        REM_OP    = 3'b110,
        REMU_OP   = 3'b111
    } mdu_op_e;

    // Multiplier request.
    typedef struct packed {
        // Multiplicand.
        word_t a;
        // Multiplier.
        word_t b;
        // Treat a as two's complement.
        logic  a_signed;
        // Treat b as two's complement.
        logic  b_signed;
        // Return bits 63:32 of the product.
        logic  high_word;
    } mul_req_t;

    // Divider request.
    typedef struct packed {
        // Dividend.
        word_t num;
        // Divisor.
        word_t den;
        // DIV and REM.
        logic  signed_op;
        // REM and REMU.
        logic  want_rem;
    } div_req_t;

endpackage

`default_nettype wire

/* logic/mdu_multiplier.sv */
`default_nettype none
`timescale 1ns/1ps

module mdu_multiplier (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              start_i,
    input  wire mdu_pkg::mul_req_t req_i,
    output logic                   done_o,
    output mdu_pkg::word_t         result_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } state_e;

    // Control state.
    state_e                    state_q;
    logic [mdu_pkg::CNT_W-1:0] cnt_q;
    logic                      done_q;

    // Datapath.
    mdu_pkg::dword_t prod_q;
    mdu_pkg::word_t  mcand_q;
    logic            neg_q;
    logic            high_q;
    mdu_pkg::word_t  result_q;

    // Operand magnitudes at start.
    logic            a_neg;
    logic            b_neg;
    mdu_pkg::word_t  a_mag;
    mdu_pkg::word_t  b_mag;

    // One shift-add step.
    logic [32:0]     sum;
    logic            last_iter;

    // Signed product for the final word select.
    mdu_pkg::dword_t prod_fix;

    assign a_neg = req_i.a_signed & req_i.a[31];
    assign b_neg = req_i.b_signed & req_i.b[31];
    // The most negative value maps to 2^31, which still fits unsigned.
    assign a_mag = a_neg ? -req_i.a : req_i.a;
    assign b_mag = b_neg ? -req_i.b : req_i.b;

    // Upper half accumulates, lower half holds the remaining multiplier bits.
    assign sum = {1'b0, prod_q[63:32]} + {1'b0, mcand_q & {32{prod_q[0]}}};

    assign last_iter = (cnt_q == mdu_pkg::CNT_W'(mdu_pkg::ITER_COUNT - 1));

    assign prod_fix = neg_q ? -prod_q : prod_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_iter) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    // Result is registered on this edge.
                    state_q <= IDLE;
                    done_q  <= 1'b1;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    prod_q  <= {32'd0, b_mag};
                    mcand_q <= a_mag;
                    neg_q   <= a_neg ^ b_neg;
                    high_q  <= req_i.high_word;
                end
            end
            RUN: begin
                prod_q <= {sum, prod_q[31:1]};
            end
            FIX: begin
                result_q <= high_q ? prod_fix[63:32] : prod_fix[31:0];
            end
            default: begin
            end
        endcase
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

/* logic/mdu_divider.sv */
`default_nettype none
`timescale 1ns/1ps

module mdu_divider (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              start_i,
    input  wire mdu_pkg::div_req_t req_i,
    output logic                   done_o,
    output mdu_pkg::word_t         result_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } state_e;

    // Control state.
    state_e                    state_q;
    logic [mdu_pkg::CNT_W-1:0] cnt_q;
    logic                      done_q;

    // Datapath. quo_q shifts dividend bits out and quotient bits in.
    mdu_pkg::word_t  quo_q;
    mdu_pkg::word_t  rem_q;
    mdu_pkg::word_t  den_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            want_rem_q;
    mdu_pkg::word_t  result_q;

    // Start decode.
    logic            num_neg;
    logic            den_neg;
    mdu_pkg::word_t  num_mag;
    mdu_pkg::word_t  den_mag;
    logic            den_zero;
    logic            overflow;

    // One restoring step.
    logic [32:0]     shifted;
    logic [32:0]     trial;
    logic            fits;
    logic            last_iter;

    // Sign corrected outputs.
    mdu_pkg::word_t  quo_fix;
    mdu_pkg::word_t  rem_fix;

    assign num_neg = req_i.signed_op & req_i.num[31];
    assign den_neg = req_i.signed_op & req_i.den[31];
    assign num_mag = num_neg ? -req_i.num : req_i.num;
    assign den_mag = den_neg ? -req_i.den : req_i.den;

    assign den_zero = (req_i.den == '0);
    // Most negative value divided by minus one.
    assign overflow = req_i.signed_op
                    & (req_i.num == {1'b1, 31'd0})
                    & (req_i.den == '1);

    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, den_q};
    // No borrow means the divisor fits.
    assign fits    = ~trial[32];

    assign last_iter = (cnt_q == mdu_pkg::CNT_W'(mdu_pkg::ITER_COUNT - 1));

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        cnt_q <= '0;
                        // Corner cases skip the iterations.
                        if (den_zero || overflow) begin
                            state_q <= FIX;
                        end else begin
                            state_q <= RUN;
                        end
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_iter) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    state_q <= IDLE;
                    done_q  <= 1'b1;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    want_rem_q <= req_i.want_rem;
                    den_q      <= den_mag;
                    if (den_zero) begin
                        // Quotient all ones, remainder is the dividend.
                        quo_q     <= '1;
                        rem_q     <= req_i.num;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else if (overflow) begin
                        quo_q     <= req_i.num;
                        rem_q     <= '0;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else begin
                        quo_q     <= num_mag;
                        rem_q     <= '0;
                        neg_quo_q <= num_neg ^ den_neg;
                        // Remainder follows the dividend.
                        neg_rem_q <= num_neg;
                    end
                end
            end
            RUN: begin
                quo_q <= {quo_q[30:0], fits};
                rem_q <= fits ? trial[31:0] : shifted[31:0];
            end
            FIX: begin
                result_q <= want_rem_q ? rem_fix : quo_fix;
            end
            default: begin
            end
        endcase
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

/* logic/mdu.sv */
`default_nettype none
`timescale 1ns/1ps

module mdu (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             en_i,
    input  wire mdu_pkg::word_t   alu1_i,
    input  wire mdu_pkg::word_t   alu2_i,
    input  wire mdu_pkg::mdu_op_e mdu_op_i,
    output mdu_pkg::word_t        result_o,
    output logic                  mul_stall_o,
    output logic                  div_stall_o
);

    // funct3 bit 2 selects the divide group.
    logic              is_div;
    logic              mul_en;
    logic              div_en;

    logic              mul_busy_q;
    logic              div_busy_q;
    logic              mul_start;
    logic              div_start;

    logic              mul_done;
    logic              div_done;
    mdu_pkg::word_t    mul_res;
    mdu_pkg::word_t    div_res;

    mdu_pkg::mul_req_t mul_req;
    mdu_pkg::div_req_t div_req;

    // Last retired value.
    mdu_pkg::word_t    result_q;

    assign is_div = mdu_op_i[2];
    assign mul_en = en_i & ~is_div;
    assign div_en = en_i & is_div;

    // Start only on the first enable cycle of an operation.
    assign mul_start = mul_en & ~mul_busy_q;
    assign div_start = div_en & ~div_busy_q;

    assign mul_stall_o = mul_en & ~mul_done;
    assign div_stall_o = div_en & ~div_done;

    always_comb begin
        mul_req.a         = alu1_i;
        mul_req.b         = alu2_i;
        mul_req.a_signed  = 1'b0;
        mul_req.b_signed  = 1'b0;
        mul_req.high_word = 1'b1;
        div_req.num       = alu1_i;
        div_req.den       = alu2_i;
        div_req.signed_op = 1'b0;
        div_req.want_rem  = 1'b0;
        case (mdu_op_i)
            // Low word is the same for any signedness.
            mdu_pkg::MUL_OP: begin
                mul_req.high_word = 1'b0;
            end
            mdu_pkg::MULH_OP: begin
                mul_req.a_signed = 1'b1;
                mul_req.b_signed = 1'b1;
            end
            mdu_pkg::MULHSU_OP: begin
                mul_req.a_signed = 1'b1;
            end
            mdu_pkg::DIV_OP: begin
                div_req.signed_op = 1'b1;
            end
            mdu_pkg::REM_OP: begin
                div_req.signed_op = 1'b1;
                div_req.want_rem  = 1'b1;
            end
            mdu_pkg::REMU_OP: begin
                div_req.want_rem = 1'b1;
            end
            default: begin
            end
        endcase
    end

    mdu_multiplier mul_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .req_i    (mul_req),
        .done_o   (mul_done),
        .result_o (mul_res)
    );

    mdu_divider div_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (div_start),
        .req_i    (div_req),
        .done_o   (div_done),
        .result_o (div_res)
    );

    // Busy spans start edge to the end of the done cycle.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_busy_q <= 1'b0;
            div_busy_q <= 1'b0;
            result_q   <= '0;
        end else begin
            if (mul_start) begin
                mul_busy_q <= 1'b1;
            end else if (mul_done) begin
                mul_busy_q <= 1'b0;
            end
            if (div_start) begin
                div_busy_q <= 1'b1;
            end else if (div_done) begin
                div_busy_q <= 1'b0;
            end
            if (mul_done || div_done) begin
                result_q <= result_o;
            end
        end
    end

    // Forward in the done cycle, hold afterwards.
    always_comb begin
        if (mul_done) begin
            result_o = mul_res;
        end else if (div_done) begin
            result_o = div_res;
        end else begin
            result_o = result_q;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 20 ns period.
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset covers the first two rising edges.
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/mdu_ref.svh */
`ifndef MDU_REF_SVH
`define MDU_REF_SVH

// Multiply ops by funct3[1:0]. Extended operands give the exact product mod 2^64.
function automatic mdu_pkg::word_t mul_model(input logic [1:0] sel,
                                             input mdu_pkg::word_t a,
                                             input mdu_pkg::word_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    // MULH and MULHSU take a as signed, only MULH takes b as signed.
    wa = (sel == 2'b01 || sel == 2'b10) ? {{32{a[31]}}, a} : {32'd0, a};
    wb = (sel == 2'b01) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = wa * wb;
    return (sel == 2'b00) ? prod[31:0] : prod[63:32];
endfunction

// Divide ops by funct3[1:0]. Bit 0 low means signed, bit 1 selects the remainder.
function automatic mdu_pkg::word_t div_model(input logic [1:0] sel,
                                             input mdu_pkg::word_t a,
                                             input mdu_pkg::word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    mdu_pkg::word_t     q;
    mdu_pkg::word_t     r;
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (!sel[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = '0;
    end else if (sel[0]) begin
        q = a / b;
        r = a % b;
    end else begin
        // Truncating division, so the remainder follows the dividend.
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        sq = sa / sb;
        sr = sa % sb;
        q = sq[31:0];
        r = sr[31:0];
    end
    return sel[1] ? r : q;
endfunction

`endif

/* sim/mdu_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module mdu_tb;

    localparam int RETIRE_LIMIT = 40;
    // Directed mul, directed div, random, back-to-back, hold and reset ops.
    localparam int OP_COUNT = 144 + 20 + 400 + 12 + 10 + 2;
    localparam int MAX_CYCLES = OP_COUNT * RETIRE_LIMIT + 200;

    logic             clk;
    logic             gen_rst;
    logic             abort_rst;
    logic             rst;
    logic             en;
    mdu_pkg::word_t   alu1;
    mdu_pkg::word_t   alu2;
    mdu_pkg::mdu_op_e op;
    mdu_pkg::word_t   result;
    logic             mul_stall;
    logic             div_stall;

    int               err_cnt;
    int               both_errs;
    int               class_errs;
    int               idle_errs;
    int               pass_cnt;
    int               fail_cnt;
    int               test_base;
    int               cycles = 0;
    mdu_pkg::word_t   last_exp;
    mdu_pkg::word_t   mul_vals [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                       32'h8000_0000, 32'h7fff_ffff, 32'h0001_2345};

    `include "mdu_ref.svh"

    assign rst = gen_rst | abort_rst;

    tb_clk_gen clk_gen_i (
        .clk_o (clk),
        .rst_o (gen_rst)
    );

    mdu mdu_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .en_i        (en),
        .alu1_i      (alu1),
        .alu2_i      (alu2),
        .mdu_op_i    (op),
        .result_o    (result),
        .mul_stall_o (mul_stall),
        .div_stall_o (div_stall)
    );

    stall_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mul_stall && div_stall))
        else begin
            both_errs = both_errs + 1;
            $display("%0t both stalls are high together", $time);
        end

    stall_class: assert property (@(posedge clk) disable iff (rst)
        !(mul_stall && op[2]) && !(div_stall && !op[2]))
        else begin
            class_errs = class_errs + 1;
            $display("%0t a stall rose for the wrong op class", $time);
        end

    stall_idle: assert property (@(posedge clk) disable iff (rst)
        en || (!mul_stall && !div_stall))
        else begin
            idle_errs = idle_errs + 1;
            $display("%0t a stall is high while en_i is low", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int error_total();
        return err_cnt + both_errs + class_errs + idle_errs;
    endfunction

    task automatic check_result(input mdu_pkg::word_t exp);
        assert (result == exp) else begin
            $display("ERR %0t result_o expected %h got %h", $time, exp, result);
            err_cnt++;
        end
    endtask

    // Entered and left 2 ns after a rising edge, en_i still high on exit.
    task automatic run_op(input mdu_pkg::mdu_op_e code, input mdu_pkg::word_t a,
                          input mdu_pkg::word_t b);
        int             waited;
        mdu_pkg::word_t exp;
        exp = code[2] ? div_model(code[1:0], a, b) : mul_model(code[1:0], a, b);
        en = 1'b1;
        op = code;
        alu1 = a;
        alu2 = b;
        waited = 0;
        @(negedge clk);
        while ((mul_stall || div_stall) && waited < RETIRE_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        assert (waited < RETIRE_LIMIT) else begin
            $display("%0t %s did not retire within %0d cycles", $time, code.name(),
                     RETIRE_LIMIT);
            err_cnt++;
        end
        check_result(exp);
        last_exp = exp;
        @(posedge clk);
        #2;
    endtask

    // Class 0 multiplies, 1 divides, anything else picks either.
    task automatic run_random(input int cls);
        logic [2:0]     code;
        mdu_pkg::word_t a;
        mdu_pkg::word_t b;
        code = 3'($urandom_range(7, 0));
        if (cls == 0) begin
            code[2] = 1'b0;
        end else if (cls == 1) begin
            code[2] = 1'b1;
        end
        a = $urandom;
        b = ($urandom_range(9, 0) == 0) ? '0 : $urandom;
        run_op(mdu_pkg::mdu_op_e'(code), a, b);
    endtask

    task automatic idle_cycles(input int n);
        en = 1'b0;
        repeat (n) begin
            @(negedge clk);
            check_result(last_exp);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic finish_test(input string name);
        if (error_total() == test_base) begin
            pass_cnt++;
            $display("%0t test %s: pass", $time, name);
        end else begin
            fail_cnt++;
            $display("%0t test %s: FAIL, %0d errors", $time, name, error_total() - test_base);
        end
        test_base = error_total();
    endtask

    initial begin
        en = 1'b0;
        alu1 = '0;
        alu2 = '0;
        op = mdu_pkg::MUL_OP;
        abort_rst = 1'b0;
        err_cnt = 0;
        both_errs = 0;
        class_errs = 0;
        idle_errs = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        test_base = 0;
        last_exp = '0;
        void'($urandom(32'ha822));
        wait (!gen_rst);
        @(posedge clk);
        #2;

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    run_op(mdu_pkg::mdu_op_e'(3'(k)), mul_vals[i], mul_vals[j]);
                end
            end
        end
        idle_cycles(1);
        finish_test("directed multiply");

        for (int k = 4; k < 8; k++) begin
            run_op(mdu_pkg::mdu_op_e'(3'(k)), 32'h1234_5678, 32'h0);
            run_op(mdu_pkg::mdu_op_e'(3'(k)), 32'h8000_0001, 32'h0);
            run_op(mdu_pkg::mdu_op_e'(3'(k)), 32'h8000_0000, 32'hffff_ffff);
        end
        // Dividend and divisor signs in all four combinations.
        for (int k = 0; k < 4; k++) begin
            run_op(mdu_pkg::DIV_OP, k[0] ? 32'hffff_fff9 : 32'd7, k[1] ? 32'hffff_fffe : 32'd2);
            run_op(mdu_pkg::REM_OP, k[0] ? 32'hffff_fff9 : 32'd7, k[1] ? 32'hffff_fffe : 32'd2);
        end
        idle_cycles(1);
        finish_test("directed divide");

        repeat (400) begin
            run_random(2);
        end
        idle_cycles(1);
        finish_test("random sequence");

        // en_i stays high while the class alternates.
        for (int k = 0; k < 12; k++) begin
            run_random(k % 2);
        end
        idle_cycles(1);
        finish_test("stall protocol");

        repeat (10) begin
            run_random(2);
            idle_cycles(int'($urandom_range(8, 1)));
        end
        finish_test("result hold");

        en = 1'b1;
        op = mdu_pkg::DIV_OP;
        alu1 = 32'hdead_beef;
        alu2 = 32'h0000_0013;
        repeat (10) @(posedge clk);
        #2;
        en = 1'b0;
        abort_rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        abort_rst = 1'b0;
        @(negedge clk);
        check_result('0);
        assert (!mul_stall && !div_stall) else begin
            $display("%0t a stall is still high after reset", $time);
            err_cnt++;
        end
        @(posedge clk);
        #2;
        run_op(mdu_pkg::MULH_OP, 32'hffff_fff0, 32'h0000_0100);
        idle_cycles(2);
        finish_test("reset abort");

        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && error_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+sim
logic/mdu_pkg.sv
logic/mdu_multiplier.sv
logic/mdu_divider.sv
logic/mdu.sv
sim/tb_clk_gen.sv
sim/mdu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the MDU testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module mdu_tb -o mdu_sim
./obj_dir/mdu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
